// File: bench/control_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit_tb;
    import cpu_isa_pkg::*;
    import control_pkg::*;

    localparam int step_cycles = 2;
    localparam int ir_clr_timeout = 64;   // longest instruction is 16 clocks
    localparam control_word_t clr_only = '{drive: '0, sel: '0, load: '0, clr: 1'b1};

    // stimulus and expected strobe counts of one instruction
    typedef struct packed {
        logic [4:0] opcode;
        logic       con;
        logic [2:0] n;
        logic [1:0] reads;
        logic [1:0] writes;
        logic [1:0] rins;
        logic [1:0] pcs;
        logic [1:0] his;
        logic [1:0] los;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  stop;
    logic                  con_ff;
    logic [word_width-1:0] ir;
    control_word_t         ctrl;

    row_t   rows[$];
    load_t  prev_load;
    integer seed = 32'hbc3f;
    int     errors = 0;
    int     checks = 0;

    control_unit #(
        .step_cycles (step_cycles)
    ) dut0 (
        .clk    (clk),
        .reset  (reset),
        .stop   (stop),
        .con_ff (con_ff),
        .ir     (ir),
        .ctrl   (ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("FAIL time %0t %s: got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s, errors %0d checks %0d", why, errors, checks);
        $display("Test FAILED");
        $finish;
    endtask

    task automatic add_row(input int op, input int con, input int n, input int rd,
                           input int wr, input int rin, input int pc, input int hi,
                           input int lo);
        rows.push_back('{opcode: op, con: con, n: n, reads: rd, writes: wr,
                         rins: rin, pcs: pc, his: hi, los: lo});
    endtask

    task automatic build_rows();
        //      op con n  rd wr rin pc hi lo
        add_row(0,  0, 5, 2, 0, 1, 1, 0, 0);   // ld
        add_row(1,  0, 3, 1, 0, 1, 1, 0, 0);   // ldi
        add_row(2,  0, 5, 1, 1, 0, 1, 0, 0);   // st
        add_row(3,  0, 3, 1, 0, 1, 1, 0, 0);
        add_row(4,  0, 3, 1, 0, 1, 1, 0, 0);
        add_row(5,  0, 3, 1, 0, 1, 1, 0, 0);
        add_row(6,  0, 3, 1, 0, 1, 1, 0, 0);
        add_row(7,  0, 3, 1, 0, 1, 1, 0, 0);
        add_row(8,  0, 3, 1, 0, 1, 1, 0, 0);
        add_row(9,  0, 3, 1, 0, 1, 1, 0, 0);
        add_row(10, 0, 3, 1, 0, 1, 1, 0, 0);
        add_row(11, 0, 3, 1, 0, 1, 1, 0, 0);
        add_row(12, 0, 3, 1, 0, 1, 1, 0, 0);   // immediate group
        add_row(13, 0, 3, 1, 0, 1, 1, 0, 0);
        add_row(14, 0, 3, 1, 0, 1, 1, 0, 0);
        add_row(15, 0, 4, 1, 0, 0, 1, 1, 1);   // mul
        add_row(16, 0, 4, 1, 0, 0, 1, 1, 1);
        add_row(17, 0, 2, 1, 0, 1, 1, 0, 0);   // neg
        add_row(18, 0, 2, 1, 0, 1, 1, 0, 0);
        add_row(19, 0, 4, 1, 0, 0, 1, 0, 0);   // branch not taken
        add_row(19, 1, 4, 1, 0, 0, 2, 0, 0);   // branch taken
        add_row(20, 0, 1, 1, 0, 0, 2, 0, 0);   // jr
        add_row(21, 0, 2, 1, 0, 0, 2, 0, 0);   // jal
        add_row(22, 0, 1, 1, 0, 0, 1, 0, 0);   // in runs as nop
        add_row(23, 0, 1, 1, 0, 0, 1, 0, 0);
        add_row(24, 0, 1, 1, 0, 1, 1, 0, 0);   // mfhi
        add_row(25, 0, 1, 1, 0, 1, 1, 0, 0);
        add_row(26, 0, 1, 1, 0, 0, 1, 0, 0);   // nop
        add_row(27, 0, 1, 1, 0, 0, 1, 0, 0);
        add_row(28, 0, 1, 1, 0, 0, 1, 0, 0);
        add_row(29, 0, 1, 1, 0, 0, 1, 0, 0);
        add_row(30, 0, 1, 1, 0, 0, 1, 0, 0);
        add_row(31, 0, 1, 1, 0, 0, 1, 0, 0);
    endtask

    task automatic wait_ir_clr(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!ctrl.load.ir_clr) begin
            if (waited == ir_clr_timeout) begin
                abort_run($sformatf("timeout: no ir_clr strobe %s", what));
            end
            @(negedge clk);
            waited++;
        end
    endtask

    // runs from one ir_clr strobe to the next
    task automatic run_row(input row_t r);
        logic [31:0] low_bits;
        int          cycles;
        int          n_read, n_write, n_rin, n_pc, n_hi, n_lo;
        low_bits = $random(seed);
        cycles = 0;
        n_read = 0;
        n_write = 0;
        n_rin = 0;
        n_pc = 0;
        n_hi = 0;
        n_lo = 0;
        @(posedge clk);
        ir <= {r.opcode, low_bits[opcode_lsb-1:0]};
        con_ff <= r.con;
        forever begin
            @(negedge clk);
            cycles++;
            if (ctrl.load.ir_clr) break;
            if (cycles > ir_clr_timeout) begin
                abort_run($sformatf("timeout: opcode %0d never reached the next fetch",
                                    r.opcode));
            end
            n_read  += ctrl.load.read;
            n_write += ctrl.load.ram_write;
            n_rin   += ctrl.load.r_in;
            n_pc    += ctrl.load.pc_enable;
            n_hi    += ctrl.load.hi_enable;
            n_lo    += ctrl.load.lo_enable;
        end
        check_value($sformatf("cycles op %0d", r.opcode), cycles, (3 + r.n) * step_cycles);
        check_value($sformatf("read op %0d", r.opcode), n_read, r.reads);
        check_value($sformatf("ram_write op %0d", r.opcode), n_write, r.writes);
        check_value($sformatf("r_in op %0d", r.opcode), n_rin, r.rins);
        check_value($sformatf("pc_enable op %0d con %0d", r.opcode, r.con), n_pc, r.pcs);
        check_value($sformatf("hi_enable op %0d", r.opcode), n_hi, r.his);
        check_value($sformatf("lo_enable op %0d", r.opcode), n_lo, r.los);
    endtask

    // strobe width and read/mdr pairing on every cycle
    initial prev_load = '0;
    always @(negedge clk) begin
        check_value("load strobe held over one cycle", ctrl.load & prev_load, 0);
        if (ctrl.load.read) begin
            check_value("mdr_enable with read", ctrl.load.mdr_enable, 1);
        end
        prev_load = ctrl.load;
    end

    initial begin
        reset = 1'b1;
        stop = 1'b0;
        con_ff = 1'b0;
        ir = '0;
        build_rows();
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            check_value("ctrl in reset", ctrl, clr_only);
        end
        @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check_value("ctrl after reset", ctrl, clr_only);
        end
        wait_ir_clr("after reset");
        foreach (rows[k]) begin
            run_row(rows[k]);
        end

        // halt at the next instruction boundary
        @(posedge clk);
        ir <= {op_nop, 27'd0};
        stop <= 1'b1;
        for (int i = 0; i < 30; i++) begin
            @(negedge clk);
            check_value("ir_clr while stopped", ctrl.load.ir_clr, 0);
            if (i >= 16) begin
                check_value("ctrl while halted", ctrl, 0);
            end
        end
        @(posedge clk);
        stop <= 1'b0;
        wait_ir_clr("after stop released");

        $display("errors %0d checks %0d", errors, checks);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: control_unit.f
source/cpu_isa_pkg.sv
source/control_pkg.sv
source/opcode_decoder.sv
source/step_sequencer.sv
source/control_word_rom.sv
source/control_unit.sv
bench/control_unit_tb.sv

// File: source/control_pkg.sv
`default_nettype none

package control_pkg;

    typedef enum logic [5:0] {
        st_reset, st_halt,
        fetch0, fetch1, fetch2,
        ld3, ld4, ld5, ld6, ld7,
        ldi3, ldi4, ldi5,
        st3, st4, st5, st6, st7,
        alu3, alu4, alu5,     // also the immediate group
        imm4,                 // replaces alu4 for addi/andi/ori
        neg_not3, neg_not4,
        md3, md4, md5, md6,
        mfhi3, mflo3,
        br3, br4, br5, br6,
        jal3, jal4,
        jr3, nop3
    } step_e;

    // who drives the bus, held for the whole step
    typedef struct packed {
        logic pc_out;
        logic mdr_out;
        logic zlo_out;
        logic zhi_out;
        logic hi_out;
        logic lo_out;
        logic r_out;
        logic ba_out;
        logic c_sign_extended_out;
    } bus_drive_t;

    typedef struct packed {
        logic gra;
        logic grb;
        logic grc;
    } reg_select_t;

    // register loads, one cycle at the end of a step
    typedef struct packed {
        logic pc_enable;
        logic ir_enable;
        logic y_enable;
        logic z_enable;
        logic mar_enable;
        logic mdr_enable;
        logic hi_enable;
        logic lo_enable;
        logic con_enable;
        logic r_in;
        logic link_enable;
        logic read;
        logic ram_write;
        logic pc_increment;
        logic y_clr;
        logic ir_clr;
    } load_t;

    typedef struct packed {
        bus_drive_t  drive;
        reg_select_t sel;
        load_t       load;
        logic        clr;
    } control_word_t;

endpackage

`default_nettype wire

// File: source/control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module control_unit #(
    parameter int step_cycles = 2   // clocks per step, at least 2
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stop,
    input  logic                               con_ff,
    input  logic [cpu_isa_pkg::word_width-1:0] ir,
    output control_pkg::control_word_t         ctrl
);
    import cpu_isa_pkg::*;
    import control_pkg::*;

    instr_class_e instr_class;
    step_e        step;
    logic         last_cycle;

    opcode_decoder decoder0 (
        .clk         (clk),
        .reset       (reset),
        .ir          (ir),
        .instr_class (instr_class)
    );

    step_sequencer #(
        .step_cycles (step_cycles)
    ) sequencer0 (
        .clk         (clk),
        .reset       (reset),
        .stop        (stop),
        .instr_class (instr_class),
        .step        (step),
        .last_cycle  (last_cycle)
    );

    // ctrl trails step by one clock
    control_word_rom rom0 (
        .clk        (clk),
        .reset      (reset),
        .step       (step),
        .last_cycle (last_cycle),
        .con_ff     (con_ff),
        .ctrl       (ctrl)
    );

endmodule

`default_nettype wire

// File: source/control_word_rom.sv
`timescale 1ns/10ps
`default_nettype none

module control_word_rom (
    input  logic                       clk,
    input  logic                       reset,
    input  control_pkg::step_e         step,
    input  logic                       last_cycle,
    input  logic                       con_ff,
    output control_pkg::control_word_t ctrl
);
    import control_pkg::*;

    localparam control_word_t reset_word = '{drive: '0, sel: '0, load: '0, clr: 1'b1};

    load_t         step_load;
    control_word_t next_word;

    // one line per signal, listing the steps that assert it
    always_comb begin
        step_load.pc_enable    = (step inside {fetch1, jal4, jr3}) || (step == br6 && con_ff);
        step_load.ir_enable    = step inside {fetch2};
        step_load.y_enable     = step inside {ld3, ldi3, st3, alu3, md3, br4};
        step_load.z_enable     = step inside {fetch0, ld4, ldi4, st4, alu4, imm4,
                                              neg_not3, md4, br5};
        step_load.mar_enable   = step inside {fetch0, ld5, st5};
        step_load.mdr_enable   = step inside {fetch1, ld6, st6};
        step_load.hi_enable    = step inside {md6};
        step_load.lo_enable    = step inside {md5};
        step_load.con_enable   = step inside {br3};
        step_load.r_in         = step inside {ld7, ldi5, alu5, neg_not4, mfhi3, mflo3};
        step_load.link_enable  = step inside {jal3};
        step_load.read         = step inside {fetch1, ld6};
        step_load.ram_write    = step inside {st7};
        step_load.pc_increment = step inside {fetch0};
        step_load.y_clr        = step inside {fetch0};
        step_load.ir_clr       = step inside {fetch0};
    end

    always_comb begin
        next_word.drive.pc_out  = step inside {fetch0, br4, jal3};
        next_word.drive.mdr_out = step inside {fetch2, ld7};
        next_word.drive.zlo_out = step inside {fetch1, ld5, ldi5, st5, alu5,
                                               neg_not4, md5, br6};
        next_word.drive.zhi_out = step inside {md6};
        next_word.drive.hi_out  = step inside {mfhi3};
        next_word.drive.lo_out  = step inside {mflo3};
        next_word.drive.r_out   = step inside {st6, alu3, alu4, neg_not3, md3, md4,
                                               br3, jal4, jr3};
        next_word.drive.ba_out  = step inside {ld3, ldi3, st3};
        next_word.drive.c_sign_extended_out = step inside {ld4, ldi4, st4, imm4, br5};

        next_word.sel.gra = step inside {ld7, ldi5, st3, alu5, neg_not4, md3,
                                         mfhi3, mflo3, br3, jal4, jr3};
        next_word.sel.grb = step inside {ld3, ldi3, st6, alu3, neg_not3, md4};
        next_word.sel.grc = step inside {alu4};

        next_word.load = '0;
        if (last_cycle) begin
            next_word.load = step_load;   // loads only in the closing cycle
        end

        next_word.clr = (step == st_reset);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ctrl <= reset_word;
        end else begin
            ctrl <= next_word;
        end
    end

endmodule

`default_nettype wire

// File: source/cpu_isa_pkg.sv
`default_nettype none

package cpu_isa_pkg;

    localparam int word_width = 32;
    localparam int opcode_width = 5;
    localparam int opcode_lsb = 27;   // opcode sits in ir[31:27]

    typedef enum logic [opcode_width-1:0] {
        op_ld   = 5'd0,
        op_ldi  = 5'd1,
        op_st   = 5'd2,
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_shr  = 5'd5,
        op_shra = 5'd6,
        op_shl  = 5'd7,
        op_ror  = 5'd8,
        op_rol  = 5'd9,
        op_and  = 5'd10,
        op_or   = 5'd11,
        op_addi = 5'd12,
        op_andi = 5'd13,
        op_ori  = 5'd14,
        op_mul  = 5'd15,
        op_div  = 5'd16,
        op_neg  = 5'd17,
        op_not  = 5'd18,
        op_br   = 5'd19,
        op_jr   = 5'd20,
        op_jal  = 5'd21,
        op_in   = 5'd22,
        op_out  = 5'd23,
        op_mfhi = 5'd24,
        op_mflo = 5'd25,
        op_nop  = 5'd26
    } opcode_e;

    // one class per distinct step sequence
    typedef enum logic [3:0] {
        cls_ld, cls_ldi, cls_st,
        cls_alu3, cls_alu_imm,
        cls_neg_not, cls_mul_div,
        cls_mfhi, cls_mflo,
        cls_branch, cls_jal, cls_jr,
        cls_nop
    } instr_class_e;

endpackage

`default_nettype wire

// File: source/opcode_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module opcode_decoder (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [cpu_isa_pkg::word_width-1:0] ir,
    output cpu_isa_pkg::instr_class_e         instr_class
);
    import cpu_isa_pkg::*;

    opcode_e      opcode;
    instr_class_e decoded;

    assign opcode = opcode_e'(ir[opcode_lsb +: opcode_width]);

    always_comb begin
        case (opcode)
            op_ld:   decoded = cls_ld;
            op_ldi:  decoded = cls_ldi;
            op_st:   decoded = cls_st;
            op_add, op_sub, op_shr, op_shra, op_shl,
            op_ror, op_rol, op_and, op_or:
                decoded = cls_alu3;
            op_addi, op_andi, op_ori:
                decoded = cls_alu_imm;
            op_neg, op_not: decoded = cls_neg_not;
            op_mul, op_div: decoded = cls_mul_div;
            op_mfhi: decoded = cls_mfhi;
            op_mflo: decoded = cls_mflo;
            op_br:   decoded = cls_branch;
            op_jal:  decoded = cls_jal;
            op_jr:   decoded = cls_jr;
            op_in, op_out, op_nop:
                decoded = cls_nop;   // in/out are not sequenced
            default: decoded = cls_nop;   // 27 to 31
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            instr_class <= cls_nop;
        end else begin
            instr_class <= decoded;
        end
    end

endmodule

`default_nettype wire

// File: source/step_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

module step_sequencer #(
    parameter int step_cycles = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      stop,
    input  cpu_isa_pkg::instr_class_e instr_class,
    output control_pkg::step_e        step,
    output logic                      last_cycle
);
    import cpu_isa_pkg::*;
    import control_pkg::*;

    localparam int cnt_width = $clog2(step_cycles);

    logic [cnt_width-1:0] cnt;   // cycle within the current step
    step_e                fetch_entry;
    step_e                next_step;

    // entry step of each sequence, taken after fetch2
    function automatic step_e first_step(input instr_class_e cls);
        case (cls)
            cls_ld:      first_step = ld3;
            cls_ldi:     first_step = ldi3;
            cls_st:      first_step = st3;
            cls_alu3:    first_step = alu3;
            cls_alu_imm: first_step = alu3;
            cls_neg_not: first_step = neg_not3;
            cls_mul_div: first_step = md3;
            cls_mfhi:    first_step = mfhi3;
            cls_mflo:    first_step = mflo3;
            cls_branch:  first_step = br3;
            cls_jal:     first_step = jal3;
            cls_jr:      first_step = jr3;
            default:     first_step = nop3;
        endcase
    endfunction

    assign last_cycle = (cnt == cnt_width'(step_cycles - 1));

    // halt request is honoured only at an instruction boundary
    always_comb begin
        if (stop) begin
            fetch_entry = st_halt;
        end else begin
            fetch_entry = fetch0;
        end
    end

    always_comb begin
        case (step)
            fetch0:   next_step = fetch1;
            fetch1:   next_step = fetch2;
            fetch2:   next_step = first_step(instr_class);
            ld3:      next_step = ld4;
            ld4:      next_step = ld5;
            ld5:      next_step = ld6;
            ld6:      next_step = ld7;
            ldi3:     next_step = ldi4;
            ldi4:     next_step = ldi5;
            st3:      next_step = st4;
            st4:      next_step = st5;
            st5:      next_step = st6;
            st6:      next_step = st7;
            alu3: begin
                if (instr_class == cls_alu_imm) begin
                    next_step = imm4;
                end else begin
                    next_step = alu4;
                end
            end
            alu4, imm4: next_step = alu5;
            neg_not3: next_step = neg_not4;
            md3:      next_step = md4;
            md4:      next_step = md5;
            md5:      next_step = md6;
            br3:      next_step = br4;
            br4:      next_step = br5;
            br5:      next_step = br6;
            jal3:     next_step = jal4;
            default:  next_step = fetch_entry;   // last step of a sequence
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            step <= st_reset;
            cnt  <= '0;
        end else if (last_cycle) begin
            step <= next_step;
            cnt  <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire
